/* include/char_game_settings.svh */
`ifndef CHAR_GAME_SETTINGS_SVH
`define CHAR_GAME_SETTINGS_SVH

// visible screen area in pixels
`define HOR_PIXELS  1024
`define VER_PIXELS  768

// sprite bounding box
`define CHAR_HGT    27
`define CHAR_LNG    19

// spawn column and floor-standing row
`define CHAR_SPAWN  (`HOR_PIXELS / 5)
`define GROUND_Y    (`VER_PIXELS - 52 - `CHAR_HGT)

// motion per frame, in pixels
`define JUMP_HEIGHT 300
`define JUMP_SPEED  7
`define FALL_SPEED  5
`define MOVE_STEP   5

// hit points after reset
`define HP_START    10

// platform slots in the register table
`define NUM_PLAT    4

`endif

/* design/char_game_pkg.sv */
`default_nettype none

package char_game_pkg;

    // screen coordinate, wide enough for 1024 columns and 768 rows
    typedef logic [11:0] coord_t;

    // hit-point count
    typedef logic [3:0] hp_t;

    // platform slot number
    typedef logic [1:0] plat_idx_t;

    // true when x lies between left and right, both edges included
    function automatic logic in_span(
        input coord_t x,
        input coord_t left,
        input coord_t right
    );
        return (x >= left) && (x <= right);
    endfunction

endpackage

`default_nettype wire

/* design/char_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface char_if;
    import char_game_pkg::*;

    // sprite position, top-left corner
    coord_t pos_x;
    coord_t pos_y;

    // surface the sprite would land on, and whether it stands there now
    coord_t land_y;
    logic   on_ground;

    modport ctrl (
        output pos_x,
        output pos_y,
        input  land_y,
        input  on_ground
    );

    modport detect (
        input  pos_x,
        input  pos_y,
        output land_y,
        output on_ground
    );

endinterface

`default_nettype wire

/* design/platform_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "char_game_settings.svh"

interface platform_if;
    import char_game_pkg::*;

    // span of each platform along x
    coord_t plat_left  [`NUM_PLAT];
    coord_t plat_right [`NUM_PLAT];

    // standing row of each platform
    coord_t plat_top   [`NUM_PLAT];

    // slot in use
    logic [`NUM_PLAT-1:0] plat_en;

    modport regs (
        output plat_left,
        output plat_right,
        output plat_top,
        output plat_en
    );

    modport detect (
        input  plat_left,
        input  plat_right,
        input  plat_top,
        input  plat_en
    );

endinterface

`default_nettype wire

/* design/frame_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_tick_gen #(
    parameter int FRAME_TICKS = 65_000_000 / 60
) (
    input  logic clk,
    input  logic rst,
    output logic frame_tick
);
    localparam int CNT_W = $clog2(FRAME_TICKS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(FRAME_TICKS - 1);

    logic [CNT_W-1:0] cnt;

    // free-running frame counter, one pulse as it wraps
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt        <= '0;
            frame_tick <= 1'b0;
        end else if (cnt == CNT_LAST) begin
            cnt        <= '0;
            frame_tick <= 1'b1;
        end else begin
            cnt        <= cnt + 1'b1;
            frame_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/char_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "char_game_settings.svh"

module char_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               frame_tick,
    input  logic               stepleft,
    input  logic               stepright,
    input  logic               stepjump,
    input  logic               hit,
    char_if.ctrl               gnd,
    output char_game_pkg::hp_t char_hp,
    output logic               flip_h
);
    import char_game_pkg::*;

    localparam coord_t SPAWN_X = coord_t'(`CHAR_SPAWN);
    localparam coord_t SPAWN_Y = coord_t'(`GROUND_Y);
    localparam coord_t X_MIN   = coord_t'(`CHAR_LNG + `MOVE_STEP);
    localparam coord_t X_MAX   = coord_t'(`HOR_PIXELS - `CHAR_LNG - `MOVE_STEP);
    localparam coord_t STEP_X  = coord_t'(`MOVE_STEP);
    localparam coord_t JUMP_H  = coord_t'(`JUMP_HEIGHT);
    localparam coord_t JUMP_V  = coord_t'(`JUMP_SPEED);
    localparam coord_t FALL_V  = coord_t'(`FALL_SPEED);
    localparam hp_t    HP_INIT = hp_t'(`HP_START);

    coord_t cur_x;
    coord_t cur_y;
    coord_t jump_peak;
    coord_t peak_y;
    coord_t fall_y;
    logic   jumping;
    logic   hit_latch;
    logic   hit_pend;
    logic   alive;

    assign gnd.pos_x = cur_x;
    assign gnd.pos_y = cur_y;

    // a hit on the tick clock itself still counts for this frame
    assign hit_pend = hit_latch | hit;
    assign alive    = (char_hp != '0);

    // peak a fixed height above the take-off row
    assign peak_y = cur_y - JUMP_H;

    // one fall step clipped to the surface below
    assign fall_y = (cur_y + FALL_V < gnd.land_y) ? cur_y + FALL_V : gnd.land_y;

    // facing follows the step inputs on every clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip_h <= 1'b0;
        end else if (stepleft) begin
            flip_h <= 1'b1;
        end else if (stepright) begin
            flip_h <= 1'b0;
        end
    end

    // hits collect during the frame and cost at most one point per tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit_latch <= 1'b0;
            char_hp   <= HP_INIT;
        end else if (frame_tick) begin
            hit_latch <= 1'b0;
            if (hit_pend && alive) begin
                char_hp <= char_hp - hp_t'(1);
            end
        end else if (hit) begin
            hit_latch <= 1'b1;
        end
    end

    // horizontal walk where left wins and screen edges stop the sprite
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_x <= SPAWN_X;
        end else if (frame_tick && alive) begin
            if (stepleft && cur_x > X_MIN) begin
                cur_x <= cur_x - STEP_X;
            end else if (stepright && cur_x < X_MAX) begin
                cur_x <= cur_x + STEP_X;
            end
        end
    end

    // jump, rise and fall
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_y     <= SPAWN_Y;
            jumping   <= 1'b0;
            jump_peak <= '0;
        end else if (frame_tick && alive) begin
            if (jumping) begin
                // rising ignores platforms overhead
                if (cur_y > jump_peak + JUMP_V) begin
                    cur_y <= cur_y - JUMP_V;
                end else begin
                    jumping <= 1'b0;
                end
            end else if (gnd.on_ground) begin
                if (stepjump) begin
                    jumping   <= 1'b1;
                    jump_peak <= peak_y;
                end
            end else begin
                cur_y <= fall_y;
            end
        end
    end

endmodule

`default_nettype wire

/* design/ground_detect.sv */
`timescale 1ns/1ps
`default_nettype none
`include "char_game_settings.svh"

module ground_detect (
    char_if.detect     chr,
    platform_if.detect plat
);
    import char_game_pkg::*;

    localparam coord_t FLOOR_Y = coord_t'(`GROUND_Y);

    coord_t best_y;
    logic   [`NUM_PLAT-1:0] cand;

    // platforms that cover the sprite column and lie at or below it
    always_comb begin
        for (int i = 0; i < `NUM_PLAT; i++) begin
            cand[i] = plat.plat_en[i]
                   && in_span(chr.pos_x, plat.plat_left[i], plat.plat_right[i])
                   && (plat.plat_top[i] >= chr.pos_y);
        end
    end

    // floor covers every column, so it is the fallback surface
    always_comb begin
        best_y = FLOOR_Y;
        for (int i = 0; i < `NUM_PLAT; i++) begin
            if (cand[i] && plat.plat_top[i] < best_y) begin
                best_y = plat.plat_top[i];
            end
        end
    end

    assign chr.land_y    = best_y;
    assign chr.on_ground = (chr.pos_y == best_y);

endmodule

`default_nettype wire

/* design/platform_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "char_game_settings.svh"

module platform_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cfg_we,
    input  logic [1:0]               cfg_sel,
    input  char_game_pkg::plat_idx_t cfg_idx,
    input  char_game_pkg::coord_t    cfg_data,
    platform_if.regs                 plat
);
    import char_game_pkg::*;

    // field codes on cfg_sel
    localparam logic [1:0] SEL_LEFT  = 2'd0;
    localparam logic [1:0] SEL_RIGHT = 2'd1;
    localparam logic [1:0] SEL_TOP   = 2'd2;
    localparam logic [1:0] SEL_EN    = 2'd3;

    coord_t left_q  [`NUM_PLAT];
    coord_t right_q [`NUM_PLAT];
    coord_t top_q   [`NUM_PLAT];
    logic   [`NUM_PLAT-1:0] en_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            en_q <= '0;
            for (int i = 0; i < `NUM_PLAT; i++) begin
                left_q[i]  <= '0;
                right_q[i] <= '0;
                top_q[i]   <= '0;
            end
        end else if (cfg_we) begin
            case (cfg_sel)
                SEL_LEFT:  left_q[cfg_idx]  <= cfg_data;
                SEL_RIGHT: right_q[cfg_idx] <= cfg_data;
                SEL_TOP:   top_q[cfg_idx]   <= cfg_data;
                // only bit 0 matters for the enable
                SEL_EN:    en_q[cfg_idx]    <= cfg_data[0];
            endcase
        end
    end

    assign plat.plat_left  = left_q;
    assign plat.plat_right = right_q;
    assign plat.plat_top   = top_q;
    assign plat.plat_en    = en_q;

endmodule

`default_nettype wire

/* design/char_game_top.sv */
`timescale 1ns/1ps
`default_nettype none

module char_game_top #(
    parameter int FRAME_TICKS = 65_000_000 / 60
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stepleft,
    input  logic                     stepright,
    input  logic                     stepjump,
    input  logic                     hit,
    input  logic                     cfg_we,
    input  logic [1:0]               cfg_sel,
    input  char_game_pkg::plat_idx_t cfg_idx,
    input  char_game_pkg::coord_t    cfg_data,
    output char_game_pkg::coord_t    pos_x,
    output char_game_pkg::coord_t    pos_y,
    output logic                     on_ground,
    output logic                     flip_h,
    output char_game_pkg::hp_t       char_hp
);
    logic frame_tick;

    char_if     chr_bus ();
    platform_if plat_bus ();

    frame_tick_gen #(
        .FRAME_TICKS (FRAME_TICKS)
    ) u_frame_tick_gen (
        .clk        (clk),
        .rst        (rst),
        .frame_tick (frame_tick)
    );

    char_ctrl u_char_ctrl (
        .clk        (clk),
        .rst        (rst),
        .frame_tick (frame_tick),
        .stepleft   (stepleft),
        .stepright  (stepright),
        .stepjump   (stepjump),
        .hit        (hit),
        .gnd        (chr_bus.ctrl),
        .char_hp    (char_hp),
        .flip_h     (flip_h)
    );

    ground_detect u_ground_detect (
        .chr  (chr_bus.detect),
        .plat (plat_bus.detect)
    );

    platform_regs u_platform_regs (
        .clk      (clk),
        .rst      (rst),
        .cfg_we   (cfg_we),
        .cfg_sel  (cfg_sel),
        .cfg_idx  (cfg_idx),
        .cfg_data (cfg_data),
        .plat     (plat_bus.regs)
    );

    // sprite state out to the pixel side
    assign pos_x     = chr_bus.pos_x;
    assign pos_y     = chr_bus.pos_y;
    assign on_ground = chr_bus.on_ground;

endmodule

`default_nettype wire

/* test/char_game_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "char_game_settings.svh"

module char_game_tb;
    import char_game_pkg::*;

    localparam int  FT          = 24;
    localparam int  CLK_PERIOD  = 100;
    localparam int  INPUT_DELAY = 5;
    localparam int  SEED        = 6459;

    // frame budget of each test
    localparam int  WALK_FRAMES  = 200;
    localparam int  EDGE_FRAMES  = 200;
    localparam int  JUMP_FRAMES  = 121;
    localparam int  PLAT_FRAMES  = 410;
    localparam int  HIT_FRAMES   = 44;
    localparam int  FACE_FRAMES  = 10;
    localparam int  TOTAL_FRAMES = WALK_FRAMES + 2 * EDGE_FRAMES + JUMP_FRAMES
                                 + PLAT_FRAMES + HIT_FRAMES + FACE_FRAMES;
    localparam real WATCHDOG_NS  = 2.0 * TOTAL_FRAMES * FT * CLK_PERIOD;

    localparam coord_t GROUND  = coord_t'(`GROUND_Y);
    localparam coord_t X_MIN   = coord_t'(`CHAR_LNG + `MOVE_STEP);
    localparam coord_t X_MAX   = coord_t'(`HOR_PIXELS - `CHAR_LNG - `MOVE_STEP);

    logic      clk;
    logic      rst;
    logic      stepleft;
    logic      stepright;
    logic      stepjump;
    logic      hit;
    logic      cfg_we;
    logic [1:0] cfg_sel;
    plat_idx_t cfg_idx;
    coord_t    cfg_data;
    coord_t    pos_x;
    coord_t    pos_y;
    logic      on_ground;
    logic      flip_h;
    hp_t       char_hp;

    // reference model state
    coord_t m_x;
    coord_t m_y;
    coord_t m_peak;
    logic   m_jump;
    logic   m_flip;
    logic   m_latch;
    hp_t    m_hp;
    coord_t m_left  [`NUM_PLAT];
    coord_t m_right [`NUM_PLAT];
    coord_t m_top   [`NUM_PLAT];
    logic   m_en    [`NUM_PLAT];

    int     edge_cnt;
    int     plat_landings;
    int     mismatches;
    int     other_errors;
    logic   face_each;
    string  test_name;
    coord_t frozen_x;
    coord_t frozen_y;

    char_game_top #(
        .FRAME_TICKS (FT)
    ) u_char_game_top (
        .clk       (clk),
        .rst       (rst),
        .stepleft  (stepleft),
        .stepright (stepright),
        .stepjump  (stepjump),
        .hit       (hit),
        .cfg_we    (cfg_we),
        .cfg_sel   (cfg_sel),
        .cfg_idx   (cfg_idx),
        .cfg_data  (cfg_data),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .on_ground (on_ground),
        .flip_h    (flip_h),
        .char_hp   (char_hp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished, the run looks hung");
        $display("sim failed");
        $finish;
    end

    task automatic check_coord(input string sig, input coord_t exp, input coord_t act);
        if (exp !== act) begin
            mismatches++;
            $display("Mismatch %s %s: expected %0d, actual %0d", test_name, sig, exp, act);
        end
    endtask

    task automatic check_hp(input string sig, input hp_t exp, input hp_t act);
        if (exp !== act) begin
            mismatches++;
            $display("Mismatch %s %s: expected %0d, actual %0d", test_name, sig, exp, act);
        end
    endtask

    task automatic check_bit(input string sig, input logic exp, input logic act);
        if (exp !== act) begin
            mismatches++;
            $display("Mismatch %s %s: expected %b, actual %b", test_name, sig, exp, act);
        end
    endtask

    // nearest covering surface at or below y
    function automatic coord_t surface_below(input coord_t x, input coord_t y);
        coord_t best;
        best = GROUND;
        for (int i = 0; i < `NUM_PLAT; i++) begin
            if (m_en[i] && in_span(x, m_left[i], m_right[i]) && m_top[i] >= y
                    && m_top[i] < best) begin
                best = m_top[i];
            end
        end
        return best;
    endfunction

    // one clock edge of the reference model using pre-edge state
    task automatic model_edge();
        coord_t land;
        logic   tick;
        edge_cnt++;
        tick = (edge_cnt > FT) && ((edge_cnt - 1) % FT == 0);
        land = surface_below(m_x, m_y);
        if (tick) begin
            if (m_hp != 0) begin
                if (stepleft && m_x > X_MIN) begin
                    m_x = m_x - coord_t'(`MOVE_STEP);
                end else if (stepright && m_x < X_MAX) begin
                    m_x = m_x + coord_t'(`MOVE_STEP);
                end
                if (m_jump) begin
                    if (m_y > m_peak + coord_t'(`JUMP_SPEED)) begin
                        m_y = m_y - coord_t'(`JUMP_SPEED);
                    end else begin
                        m_jump = 1'b0;
                    end
                end else if (m_y == land) begin
                    if (stepjump) begin
                        m_jump = 1'b1;
                        m_peak = m_y - coord_t'(`JUMP_HEIGHT);
                    end
                end else if (m_y + coord_t'(`FALL_SPEED) < land) begin
                    m_y = m_y + coord_t'(`FALL_SPEED);
                end else begin
                    m_y = land;
                    if (land != GROUND) begin
                        plat_landings++;
                    end
                end
            end
            if ((m_latch || hit) && m_hp != 0) begin
                m_hp = m_hp - hp_t'(1);
            end
            m_latch = 1'b0;
        end else if (hit) begin
            m_latch = 1'b1;
        end
        if (stepleft) begin
            m_flip = 1'b1;
        end else if (stepright) begin
            m_flip = 1'b0;
        end
        if (cfg_we) begin
            case (cfg_sel)
                2'd0: m_left[cfg_idx]  = cfg_data;
                2'd1: m_right[cfg_idx] = cfg_data;
                2'd2: m_top[cfg_idx]   = cfg_data;
                default: m_en[cfg_idx] = cfg_data[0];
            endcase
        end
    endtask

    task automatic check_frame();
        check_coord("pos_x", m_x, pos_x);
        check_coord("pos_y", m_y, pos_y);
        check_bit("on_ground", m_y == surface_below(m_x, m_y), on_ground);
        check_bit("flip_h", m_flip, flip_h);
        check_hp("char_hp", m_hp, char_hp);
    endtask

    // advance one clock and return just after the input drive point
    task automatic next_clock();
        @(posedge clk);
        model_edge();
        #(INPUT_DELAY);
        if ((edge_cnt - 1) % FT == FT / 2) begin
            check_frame();
        end
        if (face_each) begin
            check_bit("flip_h per clock", m_flip, flip_h);
        end
    endtask

    task automatic run_frames(input int n);
        repeat (n * FT) next_clock();
    endtask

    task automatic write_plat(input logic [1:0] sel, input plat_idx_t idx, input coord_t data);
        cfg_we   = 1'b1;
        cfg_sel  = sel;
        cfg_idx  = idx;
        cfg_data = data;
        next_clock();
        cfg_we   = 1'b0;
    endtask

    task automatic place_plat(input plat_idx_t idx, input coord_t l, input coord_t r,
                              input coord_t t);
        write_plat(2'd0, idx, l);
        write_plat(2'd1, idx, r);
        write_plat(2'd2, idx, t);
        write_plat(2'd3, idx, 12'd1);
    endtask

    // held step and jump requests over random stretches of frames
    task automatic random_moves(input int frames, input logic allow_jump);
        int remaining;
        int len;
        int dir;
        remaining = frames;
        while (remaining > 0) begin
            dir = $urandom % 3;
            len = 1 + $urandom % 30;
            if (len > remaining) begin
                len = remaining;
            end
            stepleft  = (dir == 0);
            stepright = (dir == 1);
            stepjump  = allow_jump && ($urandom % 2 == 1);
            run_frames(len);
            remaining -= len;
        end
        stepleft  = 1'b0;
        stepright = 1'b0;
        stepjump  = 1'b0;
    endtask

    initial begin
        void'($urandom(SEED));
        rst        = 1'b1;
        stepleft   = 1'b0;
        stepright  = 1'b0;
        stepjump   = 1'b0;
        hit        = 1'b0;
        cfg_we     = 1'b0;
        cfg_sel    = 2'd0;
        cfg_idx    = '0;
        cfg_data   = '0;
        face_each  = 1'b0;
        edge_cnt   = 0;
        mismatches = 0;
        other_errors  = 0;
        plat_landings = 0;
        m_x     = coord_t'(`CHAR_SPAWN);
        m_y     = GROUND;
        m_peak  = '0;
        m_jump  = 1'b0;
        m_flip  = 1'b0;
        m_latch = 1'b0;
        m_hp    = hp_t'(`HP_START);
        for (int i = 0; i < `NUM_PLAT; i++) begin
            m_left[i]  = '0;
            m_right[i] = '0;
            m_top[i]   = '0;
            m_en[i]    = 1'b0;
        end

        repeat (16) @(posedge clk);
        #(INPUT_DELAY);
        rst = 1'b0;

        test_name = "reset";
        check_coord("pos_x", coord_t'(`CHAR_SPAWN), pos_x);
        check_coord("pos_y", GROUND, pos_y);
        check_hp("char_hp", hp_t'(`HP_START), char_hp);
        check_bit("flip_h", 1'b0, flip_h);
        check_bit("on_ground", 1'b1, on_ground);

        test_name = "walk";
        random_moves(WALK_FRAMES, 1'b0);

        // long holds that run into both screen edges
        test_name = "edges";
        stepleft  = 1'b1;
        run_frames(EDGE_FRAMES);
        stepleft  = 1'b0;
        stepright = 1'b1;
        run_frames(EDGE_FRAMES);
        stepright = 1'b0;

        // a one-frame request followed by mid-air requests that must be ignored
        test_name = "jump";
        stepjump  = 1'b1;
        run_frames(1);
        stepright = 1'b1;
        run_frames(40);
        stepjump  = 1'b0;
        stepright = 1'b0;
        run_frames(JUMP_FRAMES - 41);
        check_coord("landed pos_y", GROUND, pos_y);
        check_bit("landed on_ground", 1'b1, on_ground);

        test_name = "platform";
        place_plat(2'd0, 12'd100, 12'd400, 12'd520);
        place_plat(2'd1, 12'd380, 12'd700, 12'd440);
        place_plat(2'd2, 12'd650, 12'd950, 12'd600);
        place_plat(2'd3, 12'd200, 12'd900, 12'd650);
        random_moves(300, 1'b1);
        write_plat(2'd3, 2'd3, 12'd0);
        write_plat(2'd3, 2'd1, 12'd0);
        random_moves(PLAT_FRAMES - 310, 1'b1);
        if (plat_landings == 0) begin
            other_errors++;
            $display("no landing on a platform top was seen in the platform test");
        end

        // forced pulse early in each window plus random extra pulses
        test_name = "hits";
        for (int f = 0; f < 14; f++) begin
            stepleft  = ($urandom % 2 == 1);
            stepright = ($urandom % 2 == 1);
            stepjump  = ($urandom % 2 == 1);
            for (int c = 0; c < FT; c++) begin
                hit = (c == 3) || ($urandom % 6 == 0);
                next_clock();
            end
        end
        hit = 1'b0;
        check_hp("saturated char_hp", hp_t'(0), char_hp);
        frozen_x = m_x;
        frozen_y = m_y;
        test_name = "frozen";
        for (int c = 0; c < (HIT_FRAMES - 14) * FT; c++) begin
            stepleft  = ($urandom % 2 == 1);
            stepright = ($urandom % 2 == 1);
            stepjump  = ($urandom % 2 == 1);
            hit       = ($urandom % 4 == 0);
            next_clock();
        end
        hit = 1'b0;
        check_coord("frozen pos_x", frozen_x, pos_x);
        check_coord("frozen pos_y", frozen_y, pos_y);

        test_name = "facing";
        face_each = 1'b1;
        for (int c = 0; c < FACE_FRAMES * FT; c++) begin
            stepleft  = ($urandom % 2 == 1);
            stepright = ($urandom % 2 == 1);
            next_clock();
        end
        face_each = 1'b0;
        stepleft  = 1'b0;
        stepright = 1'b0;
        next_clock();

        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* char_game.f */
+incdir+include
design/char_game_pkg.sv
design/char_if.sv
design/platform_if.sv
design/frame_tick_gen.sv
design/char_ctrl.sv
design/ground_detect.sv
design/platform_regs.sv
design/char_game_top.sv
test/char_game_tb.sv
